//--- common/ac97_pkg.sv
// AC'97 controller shared definitions
// Frame geometry, slot words, codec command view and mixer bundles

package ac97_pkg;

	// Frame geometry
	localparam int FRAME_BITS = 256; // Bit clocks per frame
	localparam int SYNC_BITS  = 16;  // Sync high time, strobe cycle included
	localparam int SLOT_BITS  = 20;  // Slots 1..12
	localparam int TAG_BITS   = 16;  // Slot 0

	typedef logic [7:0]           frame_cnt_t; // Bit position inside a frame
	typedef logic [SLOT_BITS-1:0] slot_t;

	// Slot 1 as the codec sees it
	typedef struct packed {
		logic        rd;   // 1 = register read
		logic [6:0]  idx;  // Register index
		logic [11:0] rsvd; // Must stay zero
	} ac97_cmd_t;

	// Written as a command, shifted out as a plain slot word
	typedef union packed {
		ac97_cmd_t cmd;
		slot_t     raw;
	} ac97_slot1_u;

	// Slot contents for one outgoing frame, slot 1 in the top bits
	typedef struct packed {
		ac97_slot1_u slot1; // Command address
		slot_t       slot2; // Command data
		slot_t       slot3; // PCM left
		slot_t       slot4; // PCM right
	} ac97_out_frame_t;

	typedef struct packed {
		logic [3:0] ch1;
		logic [3:0] ch2;
		logic [3:0] ch3;
	} chan_levels_t;

	// Per output side
	typedef struct packed {
		logic ch1;
		logic ch2;
		logic ch3;
	} chan_en_t;

	// Codec mixer registers
	localparam logic [6:0] REG_RESET      = 7'h00;
	localparam logic [6:0] REG_MASTER_VOL = 7'h02;
	localparam logic [6:0] REG_PCM_VOL    = 7'h18;
	localparam logic [6:0] REG_POWER      = 7'h26; // Power down ctrl/status
	localparam logic [6:0] REG_VID0       = 7'h7C;
	localparam logic [6:0] REG_VID1       = 7'h7E;

	localparam logic [15:0] PCM_VOL_0DB = 16'h0808; // Unmuted, 0 dB both sides

endpackage

//--- ac97_link/ac97_link.sv
// AC'97 serial link on the codec bit clock
// Frame counter, sync and strobe decode, frame register, MSB-first shifter

module ac97_link
	import ac97_pkg::*;
(
	input  logic            ac97_bitclk,
	input  logic            rst,
	input  ac97_out_frame_t frame,
	output logic            strobe,
	output logic            ac97_sync,
	output logic            ac97_reset_b,
	output logic            ac97_sdata_out
);

	// Frame valid, slots 1-4 valid, slots 5-12 invalid, 3 spare bits
	localparam logic [TAG_BITS-1:0] TAG = {1'b1, 4'b1111, 8'b0, 3'b0};
	localparam int PAD_BITS = FRAME_BITS - TAG_BITS - $bits(ac97_out_frame_t);
	localparam frame_cnt_t LAST_BIT = frame_cnt_t'(FRAME_BITS - 1);
	localparam frame_cnt_t SYNC_END = frame_cnt_t'(SYNC_BITS - 1);

	frame_cnt_t            cnt;        // Bit currently on the wire
	logic [0:FRAME_BITS-1] frame_q;    // Index 0 leaves first
	logic [0:FRAME_BITS-1] frame_next;

	// Tag, then slots 1-4, then zeros for slots 5-12
	assign frame_next = {TAG, frame, {PAD_BITS{1'b0}}};

	// Free running, wraps once per frame
	always_ff @(posedge ac97_bitclk) begin
		if (rst)
			cnt <= '0;
		else
			cnt <= cnt + 1'b1;
	end

	// Codec held in reset with the controller
	always_ff @(posedge ac97_bitclk) begin
		if (rst) begin
			ac97_reset_b <= 1'b0;
			frame_q      <= '0; // First frame goes out empty
		end else begin
			ac97_reset_b <= 1'b1;
			if (strobe)
				frame_q <= frame_next; // Same edge the sources step on
		end
	end

	// Last bit of the frame, sources must be stable here
	assign strobe = ac97_reset_b && (cnt == LAST_BIT);

	// Rises in the last bit, falls at the end of the tag
	assign ac97_sync = ac97_reset_b && ((cnt == LAST_BIT) || (cnt < SYNC_END));

	assign ac97_sdata_out = frame_q[cnt];

	// Sync spans exactly SYNC_BITS clocks from each strobe
	property p_sync_window;
		@(posedge ac97_bitclk) disable iff (rst)
		strobe |-> ac97_sync [*SYNC_BITS] ##1 !ac97_sync;
	endproperty
	a_sync_window: assert property (p_sync_window)
		else $error("sync window does not follow strobe");

	// No frame boundary while the link is held in reset
	property p_no_strobe_in_rst;
		@(posedge ac97_bitclk)
		(rst ##1 rst) |-> !strobe;
	endproperty
	a_no_strobe_in_rst: assert property (p_no_strobe_in_rst)
		else $error("strobe during reset");

endmodule

//--- verilog/ac97_codec_cfg.sv
// Codec configuration sequencer
// One-time volume setup, then an endless poll of status and vendor ID

module ac97_codec_cfg
	import ac97_pkg::*;
(
	input  logic        ac97_bitclk,
	input  logic        rst,
	input  logic        strobe,
	output ac97_slot1_u slot1,
	output slot_t       slot2
);

	localparam logic [2:0] ST_RESET  = 3'd0;
	localparam logic [2:0] ST_MASTER = 3'd1;
	localparam logic [2:0] ST_PCM    = 3'd2;
	localparam logic [2:0] ST_POWER  = 3'd3; // Poll loop starts here
	localparam logic [2:0] ST_VID0   = 3'd4;
	localparam logic [2:0] ST_VID1   = 3'd5;

	logic [2:0]  step;
	logic [2:0]  step_next;
	logic [15:0] wr_data;

	always_comb begin
		slot1     = '0;
		wr_data   = 16'h0000; // Reads carry no data
		step_next = ST_RESET;
		case (step)
			ST_RESET: begin
				slot1.cmd.idx = REG_RESET;
				step_next     = ST_MASTER;
			end
			ST_MASTER: begin
				slot1.cmd.idx = REG_MASTER_VOL; // Unmuted, full scale
				step_next     = ST_PCM;
			end
			ST_PCM: begin
				slot1.cmd.idx = REG_PCM_VOL;
				wr_data       = PCM_VOL_0DB;
				step_next     = ST_POWER;
			end
			ST_POWER: begin
				slot1.cmd.rd  = 1'b1;
				slot1.cmd.idx = REG_POWER;
				step_next     = ST_VID0;
			end
			ST_VID0: begin
				slot1.cmd.rd  = 1'b1;
				slot1.cmd.idx = REG_VID0;
				step_next     = ST_VID1;
			end
			ST_VID1: begin
				slot1.cmd.rd  = 1'b1;
				slot1.cmd.idx = REG_VID1;
				step_next     = ST_POWER; // Back to the poll
			end
			default: step_next = ST_RESET;
		endcase
	end

	assign slot2 = {wr_data, 4'b0000}; // Data sits in the top 16 bits

	// Steps only at frame boundaries
	always_ff @(posedge ac97_bitclk) begin
		if (rst)
			step <= ST_RESET;
		else if (strobe)
			step <= step_next;
	end

	a_step_range: assert property (@(posedge ac97_bitclk) disable iff (rst) step <= ST_VID1)
		else $error("config step out of range");

endmodule

//--- verilog/ac97_mixer.sv
// Three-channel PCM mixer for one output slot
// Single active channel at full level, several at half level each

module ac97_mixer
	import ac97_pkg::*;
#(
	parameter logic [3:0] VOLUME_SHIFT = 4'd14 // Level to sample scaling
) (
	input  logic         master_en,
	input  chan_en_t     chan_en,
	input  chan_levels_t levels,
	output slot_t        sample
);

	logic [2:0] active;  // ch1 in the top bit
	logic [3:0] ch1_lvl; // Zero unless active
	logic [3:0] ch2_lvl;
	logic [3:0] ch3_lvl;
	logic [5:0] mix_sum; // One spare bit for the range check

	// Enabled and actually producing sound
	assign active = {chan_en.ch1 && (levels.ch1 != 4'd0),
	                 chan_en.ch2 && (levels.ch2 != 4'd0),
	                 chan_en.ch3 && (levels.ch3 != 4'd0)};

	assign ch1_lvl = active[2] ? levels.ch1 : 4'd0;
	assign ch2_lvl = active[1] ? levels.ch2 : 4'd0;
	assign ch3_lvl = active[0] ? levels.ch3 : 4'd0;

	always_comb begin
		if ($onehot(active)) begin
			// Only one nonzero, OR picks it out
			mix_sum = {2'b00, ch1_lvl | ch2_lvl | ch3_lvl};
		end else begin
			// Halves rounded down, no active channel gives zero
			mix_sum = {3'b000, ch1_lvl[3:1]}
			        + {3'b000, ch2_lvl[3:1]}
			        + {3'b000, ch3_lvl[3:1]};
		end
	end

	// Master mute overrides everything
	assign sample = master_en ? (slot_t'(mix_sum) << VOLUME_SHIFT) : '0;

	// Three halves top out at 21, one full level at 15
	always_comb begin
		assert (mix_sum[5] == 1'b0)
			else $error("mixer sum overflows 5 bits");
	end

endmodule

//--- verilog/ac97_top.sv
// AC'97 controller top level
// Link, codec setup sequencer and left/right PCM mixers on the bit clock

module ac97_top
	import ac97_pkg::*;
#(
	parameter logic [3:0] VOLUME_SHIFT = 4'd14 // Shared by both mixers
) (
	input  logic         ac97_bitclk,
	input  logic         rst,
	input  logic         master_sound_enable,
	input  chan_en_t     so1_en,  // Left side enables
	input  chan_en_t     so2_en,  // Right side enables
	input  chan_levels_t levels,
	output logic         ac97_sdata_out,
	output logic         ac97_sync,
	output logic         ac97_reset_b,
	output logic         strobe
);

	ac97_slot1_u     slot1;       // Command address
	slot_t           slot2;       // Command data
	slot_t           pcm_left;
	slot_t           pcm_right;
	ac97_out_frame_t frame;

	assign frame = '{slot1: slot1, slot2: slot2, slot3: pcm_left, slot4: pcm_right};

	ac97_link u_link (
		.ac97_bitclk    (ac97_bitclk),
		.rst            (rst),
		.frame          (frame),
		.strobe         (strobe),
		.ac97_sync      (ac97_sync),
		.ac97_reset_b   (ac97_reset_b),
		.ac97_sdata_out (ac97_sdata_out)
	);

	ac97_codec_cfg u_cfg (
		.ac97_bitclk (ac97_bitclk),
		.rst         (rst),
		.strobe      (strobe), // Next command per frame
		.slot1       (slot1),
		.slot2       (slot2)
	);

	// Slot 3
	ac97_mixer #(.VOLUME_SHIFT(VOLUME_SHIFT)) mix_left (
		.master_en (master_sound_enable),
		.chan_en   (so1_en),
		.levels    (levels),
		.sample    (pcm_left)
	);

	// Slot 4, same levels with its own enables
	ac97_mixer #(.VOLUME_SHIFT(VOLUME_SHIFT)) mix_right (
		.master_en (master_sound_enable),
		.chan_en   (so2_en),
		.levels    (levels),
		.sample    (pcm_right)
	);

endmodule

//--- dv/tb_ac97.sv
// AC'97 controller testbench
// Directed tests for reset, frame timing, codec commands and PCM mixing

module tb_ac97
	import ac97_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int         CLK_PERIOD   = 10;
	localparam int         RST_CYCLES   = 8;
	localparam logic [3:0] VOLUME_SHIFT = 4'd14;
	localparam int         CMD_FRAMES   = 9;  // Setup once plus two poll rounds
	localparam int         MIX_SETS     = 8;
	// Frame 0, command frames, two frames per mix set and for mute, slack
	localparam int         RUN_FRAMES   = 1 + CMD_FRAMES + 2 * (MIX_SETS + 1) + 4;
	localparam longint     TIMEOUT_NS   = longint'(RUN_FRAMES) * FRAME_BITS * CLK_PERIOD
	                                      + RST_CYCLES * CLK_PERIOD;

	logic         ac97_bitclk = 1'b0;
	logic         rst;
	logic         master_sound_enable;
	chan_en_t     so1_en;
	chan_en_t     so2_en;
	chan_levels_t levels;
	logic         ac97_sdata_out;
	logic         ac97_sync;
	logic         ac97_reset_b;
	logic         strobe;

	integer                seed        = 32'h90f759e8;
	int                    err_count   = 0;
	int                    check_count = 0;
	logic [0:FRAME_BITS-1] frame_log [$]; // Frame 1 onward, index 0 = first bit sent
	int                    frame_total = 0;
	logic [0:FRAME_BITS-1] cur_frame;
	int                    bit_idx     = 0;
	logic                  capturing   = 1'b0;

	ac97_top #(.VOLUME_SHIFT(VOLUME_SHIFT)) DUT (
		.ac97_bitclk         (ac97_bitclk),
		.rst                 (rst),
		.master_sound_enable (master_sound_enable),
		.so1_en              (so1_en),
		.so2_en              (so2_en),
		.levels              (levels),
		.ac97_sdata_out      (ac97_sdata_out),
		.ac97_sync           (ac97_sync),
		.ac97_reset_b        (ac97_reset_b),
		.strobe              (strobe)
	);

	always #(CLK_PERIOD / 2) ac97_bitclk = ~ac97_bitclk;

	task automatic compare(input string name, input logic [31:0] expected,
	                       input logic [31:0] actual);
		check_count++;
		if (actual !== expected) begin
			err_count++;
			$display("FAILED at %0d ns: %s expected 0x%0h, got 0x%0h",
			         $time, name, expected, actual);
		end
	endtask

	// Outputs sampled mid-cycle, bit 0 is the cycle after strobe
	always @(negedge ac97_bitclk) begin
		if (capturing && bit_idx < FRAME_BITS) begin
			// Sync covers the strobe cycle and the next 15 bits
			compare("ac97_sync", 32'((bit_idx < SYNC_BITS - 1) || (bit_idx == FRAME_BITS - 1)),
			        32'(ac97_sync));
			compare("strobe", 32'(bit_idx == FRAME_BITS - 1), 32'(strobe));
			cur_frame[bit_idx] = ac97_sdata_out;
			bit_idx++;
		end
		if (strobe === 1'b1) begin
			if (capturing) begin
				compare("bits per frame", FRAME_BITS, bit_idx);
				frame_fixed_fields(cur_frame, frame_total + 1); // Tag and zero tail
				frame_log.push_back(cur_frame);
				frame_total++;
			end
			capturing = 1'b1;
			bit_idx   = 0;
		end
	end

	// Ends on the edge that closes the strobe cycle
	task automatic wait_frames(input int target);
		while (frame_total < target)
			@(posedge ac97_bitclk);
	endtask

	function automatic slot_t slot_of(input logic [0:FRAME_BITS-1] f, input int n);
		return f[TAG_BITS + SLOT_BITS * (n - 1) +: SLOT_BITS]; // MSB first on the wire
	endfunction

	// Slot 1 in the top 20 bits, slot 2 below
	function automatic logic [39:0] expected_cmd(input int step);
		logic        rd;
		logic [6:0]  idx;
		logic [15:0] data;
		rd   = 1'b0;
		data = 16'h0000;
		case (step)
			0: idx = REG_RESET;
			1: idx = REG_MASTER_VOL;
			2: begin
				idx  = REG_PCM_VOL;
				data = PCM_VOL_0DB;
			end
			3: begin
				rd  = 1'b1;
				idx = REG_POWER;
			end
			4: begin
				rd  = 1'b1;
				idx = REG_VID0;
			end
			default: begin
				rd  = 1'b1;
				idx = REG_VID1;
			end
		endcase
		return {rd, idx, 12'h000, data, 4'h0};
	endfunction

	// Reference mix rule
	function automatic slot_t mix_expect(input logic master, input chan_en_t en,
	                                     input chan_levels_t lv);
		logic [3:0] lvl [3];
		logic       on  [3];
		int         n_on;
		int         sum;
		int         k;
		lvl[0] = lv.ch1;
		lvl[1] = lv.ch2;
		lvl[2] = lv.ch3;
		on[0]  = en.ch1 && (lv.ch1 != 0);
		on[1]  = en.ch2 && (lv.ch2 != 0);
		on[2]  = en.ch3 && (lv.ch3 != 0);
		n_on   = 0;
		sum    = 0;
		for (k = 0; k < 3; k++)
			if (on[k])
				n_on++;
		if (!master || n_on == 0)
			return '0;
		for (k = 0; k < 3; k++)
			if (on[k])
				sum += (n_on == 1) ? int'(lvl[k]) : int'(lvl[k]) / 2; // Halves round down
		return slot_t'(sum << VOLUME_SHIFT);
	endfunction

	task automatic frame_fixed_fields(input logic [0:FRAME_BITS-1] f, input int k);
		compare($sformatf("frame %0d tag", k), 32'h0000_F800, 32'(f[0:TAG_BITS-1]));
		compare($sformatf("frame %0d ones in bits 96-255", k), 0,
		        $countones(f[TAG_BITS + 4 * SLOT_BITS:FRAME_BITS - 1]));
	endtask

	task automatic outputs_low(input string when);
		compare({"ac97_reset_b ", when}, 0, 32'(ac97_reset_b));
		compare({"ac97_sync ", when}, 0, 32'(ac97_sync));
		compare({"strobe ", when}, 0, 32'(strobe));
		compare({"ac97_sdata_out ", when}, 0, 32'(ac97_sdata_out));
	endtask

	task automatic reset_behavior();
		int i;
		for (i = 0; i < RST_CYCLES; i++) begin
			@(posedge ac97_bitclk);
			if (i == RST_CYCLES - 1) begin
				rst <= 1'b0; // Last reset edge
			end else begin
				@(negedge ac97_bitclk);
				outputs_low("during reset");
			end
		end
		@(negedge ac97_bitclk); // Count 0, codec reset still held
		outputs_low("on first cycle after reset");
		do begin
			@(negedge ac97_bitclk);
			compare("ac97_reset_b after reset", 1, 32'(ac97_reset_b));
			compare("ac97_sdata_out in frame 0", 0, 32'(ac97_sdata_out));
		end while (strobe !== 1'b1);
	endtask

	task automatic command_sequence();
		int          k;
		int          step;
		logic [39:0] cmd;
		wait_frames(CMD_FRAMES);
		for (k = 0; k < CMD_FRAMES; k++) begin
			step = (k < 3) ? k : 3 + (k - 3) % 3; // Setup once, then the poll loop
			cmd  = expected_cmd(step);
			compare($sformatf("frame %0d slot1", k + 1), 32'(cmd[39:20]),
			        32'(slot_of(frame_log[k], 1)));
			compare($sformatf("frame %0d slot2", k + 1), 32'(cmd[19:0]),
			        32'(slot_of(frame_log[k], 2)));
			compare($sformatf("frame %0d slot3", k + 1), 0, 32'(slot_of(frame_log[k], 3)));
			compare($sformatf("frame %0d slot4", k + 1), 0, 32'(slot_of(frame_log[k], 4)));
		end
	endtask

	task automatic random_mixing();
		int           i;
		int           n;
		logic [31:0]  r;
		chan_levels_t lv;
		chan_en_t     en_l;
		chan_en_t     en_r;
		for (i = 0; i < MIX_SETS; i++) begin
			r    = $random(seed);
			lv   = r[11:0];
			en_l = r[14:12];
			en_r = r[17:15];
			if (i == 0) begin
				lv = '0; // Enabled but silent
			end else if (i == MIX_SETS - 1) begin
				lv   = 12'hFFF; // Largest three-way sum
				en_l = 3'b111;
				en_r = 3'b111;
			end else if (r[18]) begin
				lv.ch3 = 4'd0;
			end
			master_sound_enable <= 1'b1;
			levels              <= lv;
			so1_en              <= en_l;
			so2_en              <= en_r;
			n = frame_total;
			wait_frames(n + 2); // Loaded at next strobe, sent in the frame after
			compare($sformatf("mix set %0d slot3", i), 32'(mix_expect(1'b1, en_l, lv)),
			        32'(slot_of(frame_log[n + 1], 3)));
			compare($sformatf("mix set %0d slot4", i), 32'(mix_expect(1'b1, en_r, lv)),
			        32'(slot_of(frame_log[n + 1], 4)));
		end
	endtask

	task automatic master_mute();
		int          n;
		logic [31:0] r;
		r = $random(seed);
		master_sound_enable <= 1'b0;
		levels              <= r[11:0] | 12'h111; // Every level nonzero
		so1_en              <= 3'b111;
		so2_en              <= 3'b111;
		n = frame_total;
		wait_frames(n + 2);
		compare("muted slot3", 0, 32'(slot_of(frame_log[n + 1], 3)));
		compare("muted slot4", 0, 32'(slot_of(frame_log[n + 1], 4)));
	endtask

	initial begin
		rst                 = 1'b1;
		master_sound_enable = 1'b0;
		so1_en              = '0;
		so2_en              = '0;
		levels              = '0;
		reset_behavior();
		command_sequence();
		random_mixing();
		master_mute();
		$display("Checks run: %0d, errors: %0d", check_count, err_count);
		if (err_count == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	// Watchdog
	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: tests still running after %0d ns", TIMEOUT_NS);
		$display("Checks run: %0d, errors: %0d", check_count, err_count);
		$display("Something failed");
		$finish;
	end

endmodule

//--- build.f
common/ac97_pkg.sv
ac97_link/ac97_link.sv
verilog/ac97_codec_cfg.sv
verilog/ac97_mixer.sv
verilog/ac97_top.sv
dv/tb_ac97.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the AC'97 testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module tb_ac97 -f build.f -o tb_ac97
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_ac97 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Something failed" "$LOG"; then
	exit 1
fi
exit 0
